//--- hw/launcher_pkg.sv
package launcher_pkg;

	//////////////////////////////////////////////////////////////////////
	// sample format and state types
	//////////////////////////////////////////////////////////////////////

	// native adc word: bit 11 = negative, positive magnitude is ~[10:0]
	typedef logic [11:0] adc_word_t;
	typedef logic [10:0] adc_mag_t; // clipped magnitude, negative -> 0

	typedef enum logic [2:0] {
		DEB_IDLE,
		DEB_WAIT_PRESS,
		DEB_PULSE,
		DEB_HELD,
		DEB_WAIT_OFF
	} debounce_state_t;

	typedef enum logic [1:0] {
		PWM_IDLE,
		PWM_ON,
		PWM_OFF
	} pwm_state_t;

	// counter widths
	localparam int ADC_DIV_W  = 4;
	localparam int DEB_CNT_W  = 8;
	localparam int FIRE_CNT_W = 12;
	localparam int PWM_CNT_W  = 7;

	//////////////////////////////////////////////////////////////////////
	// adc receiver
	//////////////////////////////////////////////////////////////////////
	localparam int ADC_FRAME_CYC = 16;
	localparam int ADC_BITS      = 12;
	localparam logic [ADC_DIV_W-1:0] ADC_DIV_LOAD = ADC_DIV_W'(ADC_FRAME_CYC - 1);
	localparam int ADC_LOAD_TAP  = 2;  // cs delay tap that loads bit 11
	localparam int ADC_HOLD_TAP  = 14; // shift regs -> hold regs
	localparam int ADC_STRB_TAP  = 15; // new samples visible
	localparam adc_word_t ADC_BIAS_A0 = 12'd5;
	localparam adc_word_t ADC_BIAS_A1 = 12'd5;
	localparam adc_word_t ADC_BIAS_B0 = 12'd5;
	localparam adc_word_t ADC_BIAS_B1 = 12'd6;

	// fire button debounce, all counted from press start except off
	localparam logic [DEB_CNT_W-1:0] DEB_ON_CYC    = 8'd40;
	localparam logic [DEB_CNT_W-1:0] DEB_PULSE_CYC = 8'd200;
	localparam logic [DEB_CNT_W-1:0] DEB_OFF_CYC   = 8'd100;

	// firing window and arm led
	localparam logic [FIRE_CNT_W-1:0] FIRE_END_CYC      = 12'd3000;
	localparam logic [FIRE_CNT_W-1:0] SETPOINT_STEP_CYC = 12'd1200;
	localparam adc_mag_t ARM_ON_MAG  = 11'd1496; // ~300 V
	localparam adc_mag_t ARM_OFF_MAG = 11'd249;  // ~50 V
	localparam int BLINK_BIT = 9;

	// current setpoints, 205 dn per amp
	localparam adc_mag_t I_LO_HI = 11'd430; // ~2 A band
	localparam adc_mag_t I_LO_LO = 11'd390;
	localparam adc_mag_t I_HI_HI = 11'd840; // ~4 A band
	localparam adc_mag_t I_HI_LO = 11'd800;
	localparam logic [PWM_CNT_W-1:0] PWM_MIN_ON  = 7'd8;
	localparam logic [PWM_CNT_W-1:0] PWM_MAX_ON  = 7'd64;
	localparam logic [PWM_CNT_W-1:0] PWM_MIN_OFF = 7'd16;

	// burn-through
	localparam adc_mag_t I_SEEN_MAG    = 11'd100; // ~1/2 A
	localparam adc_mag_t I_LOST_MAG    = 11'd32;  // ~1/6 A
	localparam adc_mag_t VCAP_LIVE_MAG = 11'd256; // ~50 V

	// native word to magnitude, negatives clip to zero
	function automatic adc_mag_t adc_mag(input adc_word_t w);
		return w[11] ? '0 : ~w[10:0];
	endfunction

endpackage

//--- hw/adc_if.sv
`timescale 1ns/1ns

// held adc samples plus one-cycle strobe on update
interface adc_if;
	launcher_pkg::adc_word_t a0; // output current
	launcher_pkg::adc_word_t a1; // cap voltage
	launcher_pkg::adc_word_t b0; // spare
	launcher_pkg::adc_word_t b1; // output voltage
	logic strobe;                // first cycle of new samples

	modport source (
		output a0, a1, b0, b1,
		output strobe
	);

	// no back-pressure, sinks take each sample as it comes
	modport sink (
		input a0, a1, b0, b1,
		input strobe
	);
endinterface

//--- hw/adc_receiver.sv
`timescale 1ns/1ns

// free-running receiver for two dual-channel serial adcs
// one 12 bit frame per ADC_FRAME_CYC, msb first
module adc_receiver (
	input  logic       clk,
	input  logic       reset,
	input  logic [1:0] i_ad_sdata_a,
	input  logic [1:0] i_ad_sdata_b,
	output logic       o_ad_cs,
	adc_if.source      adc
);

	logic [launcher_pkg::ADC_DIV_W-1:0] div_cnt;
	logic [launcher_pkg::ADC_STRB_TAP:0] cs_dly; // cs pulse walks down this chain
	logic [3:0] sdata;                            // per channel serial bit
	launcher_pkg::adc_word_t shift_word [4];      // a0, a1, b0, b1
	launcher_pkg::adc_word_t hold_word [4];

	//////////////////////////////////////////////////////////////////////
	// chip select divider
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= launcher_pkg::ADC_DIV_LOAD; // first cs one frame out
		end else if (div_cnt == '0) begin
			div_cnt <= launcher_pkg::ADC_DIV_LOAD;
		end else begin
			div_cnt <= div_cnt - 1'b1;
		end
	end

	assign o_ad_cs = (div_cnt == '0);

	// cs delay chain, every later event is a tap
	always_ff @(posedge clk) begin
		if (reset) begin
			cs_dly <= '0;
		end else begin
			cs_dly <= {cs_dly[launcher_pkg::ADC_STRB_TAP-1:0], o_ad_cs};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// serial capture
	//////////////////////////////////////////////////////////////////////
	assign sdata = {i_ad_sdata_b[1], i_ad_sdata_b[0], i_ad_sdata_a[1], i_ad_sdata_a[0]};

	always_ff @(posedge clk) begin
		for (int ch = 0; ch < 4; ch++) begin
			// taps LOAD_TAP..LOAD_TAP+11 form the one-hot bit pointer
			for (int b = 0; b < launcher_pkg::ADC_BITS; b++) begin
				if (cs_dly[launcher_pkg::ADC_LOAD_TAP + launcher_pkg::ADC_BITS - 1 - b]) begin
					shift_word[ch][b] <= sdata[ch];
				end
			end
			if (cs_dly[launcher_pkg::ADC_HOLD_TAP]) begin
				hold_word[ch] <= shift_word[ch]; // whole frame in
			end
		end
	end

	// bias correction on the way out
	assign adc.a0 = hold_word[0] + launcher_pkg::ADC_BIAS_A0;
	assign adc.a1 = hold_word[1] + launcher_pkg::ADC_BIAS_A1;
	assign adc.b0 = hold_word[2] + launcher_pkg::ADC_BIAS_B0;
	assign adc.b1 = hold_word[3] + launcher_pkg::ADC_BIAS_B1;
	assign adc.strobe = cs_dly[launcher_pkg::ADC_STRB_TAP]; // aligned with new hold data

endmodule

//--- hw/fire_debounce.sv
`timescale 1ns/1ns

// fire button debounce
// fixed length pulse after a held press, rearm needs a held release
module fire_debounce (
	input  logic clk,
	input  logic reset,
	input  logic i_button,
	output logic o_fire
);

	logic [3:0] sync;    // 4 flop synchronizer
	logic       btn;
	launcher_pkg::debounce_state_t state;
	logic [launcher_pkg::DEB_CNT_W-1:0] press_cnt; // from press start
	logic [launcher_pkg::DEB_CNT_W-1:0] rel_cnt;   // release hold time

	always_ff @(posedge clk) begin
		if (reset) begin
			sync <= '0;
		end else begin
			sync <= {sync[2:0], i_button};
		end
	end

	assign btn = sync[3];

	//////////////////////////////////////////////////////////////////////
	// debounce fsm
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= launcher_pkg::DEB_IDLE;
		end else begin
			case (state)
				launcher_pkg::DEB_IDLE: begin
					if (btn) state <= launcher_pkg::DEB_WAIT_PRESS;
				end
				launcher_pkg::DEB_WAIT_PRESS: begin // bounce drops back to idle
					if (!btn) begin
						state <= launcher_pkg::DEB_IDLE;
					end else if (press_cnt == launcher_pkg::DEB_ON_CYC - 1'b1) begin
						state <= launcher_pkg::DEB_PULSE;
					end
				end
				launcher_pkg::DEB_PULSE: begin // runs to length regardless of button
					if (press_cnt == launcher_pkg::DEB_PULSE_CYC - 1'b1) begin
						state <= launcher_pkg::DEB_HELD;
					end
				end
				launcher_pkg::DEB_HELD: begin
					if (!btn) state <= launcher_pkg::DEB_WAIT_OFF;
				end
				launcher_pkg::DEB_WAIT_OFF: begin
					if (btn) begin
						state <= launcher_pkg::DEB_HELD; // still bouncing
					end else if (rel_cnt == launcher_pkg::DEB_OFF_CYC - 1'b1) begin
						state <= launcher_pkg::DEB_IDLE;
					end
				end
				default: state <= launcher_pkg::DEB_IDLE;
			endcase
		end
	end

	// counters only run in their own states
	always_ff @(posedge clk) begin
		if (reset) begin
			press_cnt <= '0;
			rel_cnt   <= '0;
		end else begin
			press_cnt <= (state == launcher_pkg::DEB_WAIT_PRESS ||
			              state == launcher_pkg::DEB_PULSE) ? press_cnt + 1'b1 : '0;
			rel_cnt   <= (state == launcher_pkg::DEB_WAIT_OFF) ? rel_cnt + 1'b1 : '0;
		end
	end

	assign o_fire = (state == launcher_pkg::DEB_PULSE);

endmodule

//--- hw/fire_sequencer.sv
`timescale 1ns/1ns

// firing window, auto charge and arm led
module fire_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic i_fire,
	input  logic i_autorun_n,
	input  logic i_charge_done,
	adc_if.sink  adc,
	output logic o_fire_active,
	output logic o_setpoint_high,
	output logic o_fire_done,
	output logic o_charge,
	output logic o_arm_led
);

	logic [launcher_pkg::FIRE_CNT_W-1:0] win_cnt; // 0 = not started or finished
	logic armed;
	logic [launcher_pkg::BLINK_BIT:0] free_cnt;
	launcher_pkg::adc_mag_t vcap;

	//////////////////////////////////////////////////////////////////////
	// firing window
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			win_cnt       <= '0;
			o_fire_active <= 1'b0;
			o_fire_done   <= 1'b0;
		end else if (win_cnt != '0) begin
			if (win_cnt == launcher_pkg::FIRE_END_CYC + 1'b1) begin // window over
				win_cnt       <= '0;
				o_fire_active <= 1'b0;
				o_fire_done   <= 1'b1; // sticky until reset
			end else begin
				win_cnt <= win_cnt + 1'b1;
				if (win_cnt == 1) o_fire_active <= 1'b1; // 2nd cycle after fire
			end
		end else if (i_fire && !o_fire_done) begin
			win_cnt <= 1; // once per reset
		end
	end

	// step up the current setpoint partway through
	assign o_setpoint_high = o_fire_active && (win_cnt > launcher_pkg::SETPOINT_STEP_CYC);

	//////////////////////////////////////////////////////////////////////
	// auto charge until the charger reports done
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			o_charge <= !i_autorun_n; // switch latched at reset
		end else if (i_charge_done) begin
			o_charge <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// arm led with vcap hysteresis
	//////////////////////////////////////////////////////////////////////
	assign vcap = launcher_pkg::adc_mag(adc.a1);

	always_ff @(posedge clk) begin
		if (reset) begin
			armed <= 1'b0;
		end else if (adc.strobe) begin
			if (vcap > launcher_pkg::ARM_ON_MAG) begin
				armed <= 1'b1;
			end else if (vcap < launcher_pkg::ARM_OFF_MAG) begin
				armed <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			free_cnt <= '0;
		end else begin
			free_cnt <= free_cnt + 1'b1; // blink source
		end
	end

	// solid when armed or blinking while charging
	assign o_arm_led = armed | (o_charge & free_cnt[launcher_pkg::BLINK_BIT]);

endmodule

//--- hw/pwm_current_ctrl.sv
`timescale 1ns/1ns

// hysteretic current mode pwm for the buck stage
// plus burn-through latch that shuts it down
module pwm_current_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic i_fire_active,
	input  logic i_setpoint_high,
	adc_if.sink  adc,
	output logic o_pwm,
	output logic o_burn
);

	launcher_pkg::pwm_state_t state;
	logic [launcher_pkg::PWM_CNT_W-1:0] cnt; // time in on or off
	launcher_pkg::adc_mag_t i_mag;           // negative current reads as zero
	launcher_pkg::adc_mag_t vcap;
	launcher_pkg::adc_mag_t th_hi;
	launcher_pkg::adc_mag_t th_lo;
	logic below_lo;
	logic above_hi;
	logic current_seen;

	assign i_mag = launcher_pkg::adc_mag(adc.a0);
	assign vcap  = launcher_pkg::adc_mag(adc.a1);

	// threshold pair steps from the 2 A to the 4 A band
	assign th_hi = i_setpoint_high ? launcher_pkg::I_HI_HI : launcher_pkg::I_LO_HI;
	assign th_lo = i_setpoint_high ? launcher_pkg::I_HI_LO : launcher_pkg::I_LO_LO;

	assign below_lo = (i_mag < th_lo);
	assign above_hi = (i_mag > th_hi);

	//////////////////////////////////////////////////////////////////////
	// burn-through detect
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			current_seen <= 1'b0;
			o_burn       <= 1'b0;
		end else begin
			if (i_fire_active && i_mag > launcher_pkg::I_SEEN_MAG) begin
				current_seen <= 1'b1;
			end
			// current gone (or negative) but cap still live
			if (i_fire_active && current_seen &&
			    i_mag < launcher_pkg::I_LOST_MAG &&
			    vcap > launcher_pkg::VCAP_LIVE_MAG) begin
				o_burn <= 1'b1; // holds until reset
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// pwm fsm
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= launcher_pkg::PWM_IDLE;
			cnt   <= '0;
		end else if (!i_fire_active || o_burn) begin
			state <= launcher_pkg::PWM_IDLE; // window closed or burnt through
			cnt   <= '0;
		end else begin
			case (state)
				launcher_pkg::PWM_IDLE: begin
					state <= launcher_pkg::PWM_OFF; // window just opened
					cnt   <= '0;
				end
				launcher_pkg::PWM_OFF: begin
					if (cnt >= launcher_pkg::PWM_MIN_OFF - 1'b1 && below_lo) begin
						state <= launcher_pkg::PWM_ON;
						cnt   <= '0;
					end else if (cnt < launcher_pkg::PWM_MIN_OFF - 1'b1) begin
						cnt <= cnt + 1'b1; // saturates at min off
					end
				end
				launcher_pkg::PWM_ON: begin
					if (cnt >= launcher_pkg::PWM_MIN_ON - 1'b1 &&
					    (above_hi || cnt == launcher_pkg::PWM_MAX_ON - 1'b1)) begin
						state <= launcher_pkg::PWM_OFF;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					state <= launcher_pkg::PWM_IDLE;
					cnt   <= '0;
				end
			endcase
		end
	end

	// drops at once on window end or burn while the fsm follows on the next edge
	assign o_pwm = (state == launcher_pkg::PWM_ON) && i_fire_active && !o_burn;

endmodule

//--- hw/forge_launcher.sv
`timescale 1ns/1ns

// launch controller core
// adc receiver, fire debounce, sequencer and pwm current control
module forge_launcher (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    i_fire_button,
	input  logic                    i_autorun_n,    // low = charge at power on
	input  logic                    i_charge_done,  // from the charger chip
	input  logic [1:0]              i_ad_sdata_a,
	input  logic [1:0]              i_ad_sdata_b,
	output logic                    o_ad_cs,
	output launcher_pkg::adc_word_t o_ad_a0,
	output launcher_pkg::adc_word_t o_ad_a1,
	output launcher_pkg::adc_word_t o_ad_b0,
	output launcher_pkg::adc_word_t o_ad_b1,
	output logic                    o_ad_strobe,
	output logic                    o_charge,
	output logic                    o_arm_led,
	output logic                    o_pwm,
	output logic                    o_dump,
	output logic                    o_burn,
	output logic                    o_fire_active
);

	logic fire;          // debounced one-shot
	logic setpoint_high; // 4 A band

	adc_if adc_bus ();

	adc_receiver u_adc (
		.clk          (clk),
		.reset        (reset),
		.i_ad_sdata_a (i_ad_sdata_a),
		.i_ad_sdata_b (i_ad_sdata_b),
		.o_ad_cs      (o_ad_cs),
		.adc          (adc_bus.source)
	);

	fire_debounce u_debounce (
		.clk      (clk),
		.reset    (reset),
		.i_button (i_fire_button),
		.o_fire   (fire)
	);

	fire_sequencer u_seq (
		.clk             (clk),
		.reset           (reset),
		.i_fire          (fire),
		.i_autorun_n     (i_autorun_n),
		.i_charge_done   (i_charge_done),
		.adc             (adc_bus.sink),
		.o_fire_active   (o_fire_active),
		.o_setpoint_high (setpoint_high),
		.o_fire_done     (o_dump),  // dump stays on after firing
		.o_charge        (o_charge),
		.o_arm_led       (o_arm_led)
	);

	pwm_current_ctrl u_pwm (
		.clk             (clk),
		.reset           (reset),
		.i_fire_active   (o_fire_active),
		.i_setpoint_high (setpoint_high),
		.adc             (adc_bus.sink),
		.o_pwm           (o_pwm),
		.o_burn          (o_burn)
	);

	// monitor outputs
	assign o_ad_a0     = adc_bus.a0;
	assign o_ad_a1     = adc_bus.a1;
	assign o_ad_b0     = adc_bus.b0;
	assign o_ad_b1     = adc_bus.b1;
	assign o_ad_strobe = adc_bus.strobe;

endmodule

//--- bench/launcher_assert.sv
`timescale 1ns/1ns

// pwm rules bound into the pwm controller
module launcher_assert (
	input logic                     clk,
	input logic                     reset,
	input logic                     i_fire_active,
	input logic                     o_pwm,
	input logic                     o_burn,
	input launcher_pkg::pwm_state_t state
);

	int fail_cnt = 0; // read back by the bench

	// no drive to the coil outside the firing window
	pwm_in_window: assert property (@(posedge clk) disable iff (reset)
		!i_fire_active |=> state == launcher_pkg::PWM_IDLE)
		else begin
			$error("pwm fsm not idle outside fire window");
			fail_cnt++;
		end

	// on time capped
	pwm_max_on: assert property (@(posedge clk) disable iff (reset)
		$rose(o_pwm) |-> ##[1:launcher_pkg::PWM_MAX_ON] !o_pwm)
		else begin
			$error("pwm on pulse longer than max on");
			fail_cnt++;
		end

	// burn parks the fsm for good
	pwm_off_on_burn: assert property (@(posedge clk) disable iff (reset)
		o_burn |=> state == launcher_pkg::PWM_IDLE)
		else begin
			$error("pwm fsm not idle while burn set");
			fail_cnt++;
		end

endmodule

bind pwm_current_ctrl launcher_assert u_assert (
	.clk           (clk),
	.reset         (reset),
	.i_fire_active (i_fire_active),
	.o_pwm         (o_pwm),
	.o_burn        (o_burn),
	.state         (state)
);

//--- bench/tb_launcher.sv
`timescale 1ns/1ns

module tb_launcher;

	localparam int FRAME = launcher_pkg::ADC_FRAME_CYC;
	localparam int FIRE_END = int'(launcher_pkg::FIRE_END_CYC);
	localparam int STEP = int'(launcher_pkg::SETPOINT_STEP_CYC);
	localparam int LIMIT = 4 * (FIRE_END + 2000); // run length guard

	logic clk, reset, btn, autorun_n, charge_done;
	logic [1:0] sd_a, sd_b;
	logic o_ad_cs, o_ad_strobe, o_charge, o_arm_led, o_pwm, o_dump, o_burn, o_fire_active;
	launcher_pkg::adc_word_t o_ad_a0, o_ad_a1, o_ad_b0, o_ad_b1;
	launcher_pkg::adc_word_t tx [4];      // words for the next frame
	launcher_pkg::adc_word_t frame_w [4]; // frame in flight
	launcher_pkg::adc_word_t exp_w [4];   // expected at next strobe
	int ph, cs_age, cyc, test_err, checks, tests_run, tests_failed, assert_seen;
	int t_on, el, th, m, len, pulses;
	logic [31:0] seed;

	forge_launcher UUT (
		.clk(clk), .reset(reset), .i_fire_button(btn), .i_autorun_n(autorun_n),
		.i_charge_done(charge_done), .i_ad_sdata_a(sd_a), .i_ad_sdata_b(sd_b),
		.o_ad_cs(o_ad_cs), .o_ad_a0(o_ad_a0), .o_ad_a1(o_ad_a1), .o_ad_b0(o_ad_b0),
		.o_ad_b1(o_ad_b1), .o_ad_strobe(o_ad_strobe), .o_charge(o_charge),
		.o_arm_led(o_arm_led), .o_pwm(o_pwm), .o_dump(o_dump), .o_burn(o_burn),
		.o_fire_active(o_fire_active)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic int lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return int'(seed[30:16]);
	endfunction

	// magnitude to native word with the receiver bias taken off
	function automatic launcher_pkg::adc_word_t to_word(input int mag, input int bias);
		return 12'(2047 - mag - bias);
	endfunction

	function automatic int word_mag(input launcher_pkg::adc_word_t w);
		logic [10:0] inv;
		inv = ~w[10:0];
		return w[11] ? 0 : int'(inv); // negative reads as zero
	endfunction

	function automatic logic pick(input int sel);
		case (sel)
			0: return o_pwm;
			1: return o_fire_active;
			default: return o_burn;
		endcase
	endfunction

	task automatic check_word(input string name, input launcher_pkg::adc_word_t got,
	                          input launcher_pkg::adc_word_t exp);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
			test_err++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp);
			test_err++;
		end
	endtask

	task automatic check_int(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			$display("MISMATCH t=%0t %s got %0d exp %0d", $time, name, got, exp);
			test_err++;
		end
	endtask

	task automatic wait_for(input int sel, input logic val, input int lim,
	                        input string what);
		int cnt;
		cnt = 0;
		@(negedge clk);
		while (pick(sel) !== val && cnt < lim) begin
			@(negedge clk);
			cnt++;
		end
		if (pick(sel) !== val) begin
			$display("ERROR t=%0t %s did not happen within %0d cycles", $time, what, lim);
			test_err++;
		end
	endtask

	task automatic wait_strobes(input int cnt);
		repeat (cnt) begin
			@(negedge clk);
			while (!o_ad_strobe) @(negedge clk);
		end
	endtask

	task automatic set_mags(input int cur, input int cap);
		@(posedge clk);
		tx[0] <= to_word(cur, int'(launcher_pkg::ADC_BIAS_A0));
		tx[1] <= to_word(cap, int'(launcher_pkg::ADC_BIAS_A1));
	endtask

	// wait until the new words are visible plus one edge for the consumer
	task automatic settle();
		wait_strobes(3);
		@(negedge clk);
	endtask

	task automatic finish_test(input string name);
		if (UUT.u_pwm.u_assert.fail_cnt != assert_seen) begin
			$display("ERROR t=%0t bound pwm assertion failed during this test", $time);
			test_err++;
			assert_seen = UUT.u_pwm.u_assert.fail_cnt;
		end
		tests_run++;
		if (test_err > 0) tests_failed++;
		$display("test %0d %s: %s (%0d errors)", tests_run, name,
		         (test_err > 0) ? "FAIL" : "PASS", test_err);
		test_err = 0;
	endtask

	////////////////////////////////////////////////////////////////////
	// adc serializer model driving bit 11 in cycle 3 after cs
	////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin : serializer
		int nph;
		if (reset) begin
			ph <= 0;
		end else begin
			nph = o_ad_cs ? 1 : ((ph != 0) ? ph + 1 : 0); // phase of coming cycle
			if (o_ad_cs) frame_w <= tx;
			if (nph >= 3 && nph <= 14) begin
				sd_a <= {frame_w[1][14-nph], frame_w[0][14-nph]};
				sd_b <= {frame_w[3][14-nph], frame_w[2][14-nph]};
			end
			if (nph == 15) begin // bias added per channel
				exp_w[0] <= frame_w[0] + launcher_pkg::ADC_BIAS_A0;
				exp_w[1] <= frame_w[1] + launcher_pkg::ADC_BIAS_A1;
				exp_w[2] <= frame_w[2] + launcher_pkg::ADC_BIAS_B0;
				exp_w[3] <= frame_w[3] + launcher_pkg::ADC_BIAS_B1;
			end
			ph <= nph;
		end
		cs_age <= o_ad_cs ? 1 : cs_age + 1;
	end

	// every strobe is checked whatever test runs
	always @(negedge clk) begin
		if (!reset && o_ad_strobe) begin
			check_word("o_ad_a0", o_ad_a0, exp_w[0]);
			check_word("o_ad_a1", o_ad_a1, exp_w[1]);
			check_word("o_ad_b0", o_ad_b0, exp_w[2]);
			check_word("o_ad_b1", o_ad_b1, exp_w[3]);
			check_int("cs to strobe", cs_age, FRAME);
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= LIMIT) begin
			$display("ERROR timeout, run stopped after %0d cycles", cyc);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		btn = 1'b0;
		autorun_n = 1'b0;
		charge_done = 1'b0;
		sd_a = '0;
		sd_b = '0;
		seed = 32'd42;
		ph = 0;
		cs_age = 0;
		cyc = 0;
		test_err = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		assert_seen = 0;
		for (int i = 0; i < 4; i++) tx[i] = to_word(0, 5);
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// random words over 40 frames
		repeat (40) begin
			@(posedge clk);
			for (int i = 0; i < 4; i++) tx[i] <= 12'(lcg_next());
			wait_strobes(1);
		end
		finish_test("adc receive");

		check_bit("o_charge", o_charge, 1'b1);
		@(posedge clk) charge_done <= 1'b1;
		@(posedge clk) charge_done <= 1'b0;
		@(negedge clk);
		check_bit("o_charge", o_charge, 1'b0);
		set_mags(0, 1600);
		settle();
		check_bit("o_arm_led", o_arm_led, 1'b1);
		set_mags(0, 800);
		settle();
		check_bit("o_arm_led", o_arm_led, 1'b1); // hysteresis
		set_mags(0, 100);
		settle();
		check_bit("o_arm_led", o_arm_led, 1'b0);
		set_mags(0, 800);
		settle();
		check_bit("o_arm_led", o_arm_led, 1'b0);
		finish_test("charge and arm");

		// short presses all under DEB_ON_CYC
		repeat (12) begin
			len = 1 + lcg_next() % 30;
			@(posedge clk) btn <= 1'b1;
			repeat (len) @(posedge clk);
			btn <= 1'b0;
			repeat (20 + lcg_next() % 40) begin
				@(negedge clk);
				check_bit("o_fire_active", o_fire_active, 1'b0);
			end
		end
		@(posedge clk) btn <= 1'b1;
		wait_for(1, 1'b1, 100, "fire window start on held press");
		t_on = cyc;
		finish_test("debounce");

		@(posedge clk) btn <= 1'b0;
		set_mags(300, 1600);
		pulses = 0;
		while (cyc - t_on < FIRE_END - 300) begin
			wait_for(0, 1'b1, 6 * FRAME, "pwm rise on low current");
			el = cyc - t_on;
			if (el > STEP - 3 * FRAME && el < STEP + FRAME) begin
				repeat (2 * FRAME) @(negedge clk); // too close to the step
				continue;
			end
			th = (el >= STEP) ? int'(launcher_pkg::I_HI_HI) : int'(launcher_pkg::I_LO_HI);
			set_mags(th + 40, 1600);
			m = 0;
			while (word_mag(o_ad_a0) <= th && m < 4) begin
				wait_strobes(1);
				m++;
			end
			wait_for(0, 1'b0, int'(launcher_pkg::PWM_MIN_ON) + FRAME,
			         "pwm fall above high threshold");
			set_mags(300, 1600);
			pulses++;
		end
		if (pulses < 10) begin
			$display("ERROR only %0d regulation pulses in the window", pulses);
			test_err++;
		end
		finish_test("regulation");

		wait_for(1, 1'b0, 400, "fire window end");
		check_int("window length", cyc - t_on, FIRE_END);
		check_bit("o_dump", o_dump, 1'b1);
		repeat (200) begin
			@(negedge clk);
			check_bit("o_pwm", o_pwm, 1'b0);
		end
		@(posedge clk) btn <= 1'b1; // second press must not refire
		repeat (250) begin
			@(negedge clk);
			check_bit("o_fire_active", o_fire_active, 1'b0);
		end
		@(posedge clk) btn <= 1'b0;
		repeat (150) begin
			@(negedge clk);
			check_bit("o_fire_active", o_fire_active, 1'b0);
		end
		finish_test("window end");

		@(posedge clk) begin
			reset <= 1'b1;
			autorun_n <= 1'b1;
		end
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_bit("o_charge", o_charge, 1'b0);
		check_bit("o_dump", o_dump, 1'b0);
		check_bit("o_burn", o_burn, 1'b0);
		@(posedge clk) btn <= 1'b1;
		wait_for(1, 1'b1, 100, "fire window start after reset");
		@(posedge clk) btn <= 1'b0;
		set_mags(300, 1600);
		wait_for(0, 1'b1, 6 * FRAME, "pwm rise before burn");
		set_mags(10, 1600); // current collapses while the cap stays live
		wait_for(2, 1'b1, 2 * FRAME + 2, "burn latch");
		m = 0;
		while (o_fire_active && m < FIRE_END + 100) begin
			@(negedge clk);
			check_bit("o_pwm", o_pwm, 1'b0);
			m++;
		end
		finish_test("burn-through");

		$display("tests run %0d, failed %0d, checks %0d", tests_run, tests_failed, checks);
		if (tests_failed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- filelist.f
hw/launcher_pkg.sv
hw/adc_if.sv
hw/adc_receiver.sv
hw/fire_debounce.sv
hw/fire_sequencer.sv
hw/pwm_current_ctrl.sv
hw/forge_launcher.sv
bench/launcher_assert.sv
bench/tb_launcher.sv
